// ==== Makefile ====
VERILATOR := verilator
TOP       := tb_fcore_decoder
FILELIST  := build.f
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
LINTFLAGS := --lint-only -Wall --timing --timescale 1ns/1ps
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := RESULT: FAIL
PASS_MSG  := RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
+incdir+.
fcore_decoder_pkg.sv
fcore_decoder_ifs.sv
instr_field_unpack.sv
opcode_decode.sv
issue_register.sv
fcore_decoder_top.sv
fcore_decoder_properties.sv
tb_fcore_decoder.sv

// ==== decoder_vectors.txt ====
# gap en instr ch load | exec_opcode io_a io_b io_c stop | a_valid a_addr a_target
# | b_valid b_addr b_target | c_valid c_addr | op_valid op_code (hex, gap 1 allows idle cycles first)
1 1 03211 00 000  1 0 0 0 0  1 001 003  1 002 003  0 000  1 00
0 1 37652 03 000  2 1 1 0 0  1 035 037  1 036 037  0 000  1 01
0 1 0fea1 ff 000  1 0 0 0 0  1 ffa fff  1 ffe fff  0 000  1 00
0 1 20942 ff 000  2 0 1 0 0  1 ff4 ff0  1 ff9 ff0  0 000  1 01
0 0 7abc8 12 5a5  0 0 0 0 0  0 000 000  0 000 000  0 000  0 00
1 1 71234 02 000  4 0 0 0 0  1 123 023  0 000 000  0 000  0 00
0 1 09865 05 abc  5 0 0 0 0  1 abc 056  0 000 000  0 000  0 00
1 1 74328 01 000  8 1 1 1 0  1 012 012  1 013 012  1 014  1 01
0 1 11cb6 10 000  6 1 0 1 0  1 10b 101  1 10c 101  0 014  1 24
0 1 2d217 80 000  7 0 1 1 0  1 801 80d  1 802 80d  0 014  1 14
0 1 30543 80 000  3 1 1 1 0  1 804 800  1 805 805  0 014  0 14
0 1 7fff0 33 000  0 0 0 0 0  0 000 000  0 000 000  0 000  0 00
1 1 0123c 04 000  0 0 0 0 0  0 000 000  0 000 000  0 000  0 00
1 1 00009 00 000  9 0 0 0 1  0 000 000  0 000 000  0 000  0 00
0 1 0a981 07 000  1 0 0 0 0  1 078 07a  1 079 07a  0 000  1 00
0 1 00009 07 000  9 0 0 0 1  0 078 07a  0 079 07a  0 000  0 00
0 1 53218 20 000  8 1 0 1 0  1 201 201  1 202 201  1 203  1 01
0 1 00015 20 fff  5 1 0 1 0  1 fff 201  0 202 201  0 203  0 01
0 0 00001 00 000  0 0 0 0 0  0 000 000  0 000 000  0 000  0 00
1 1 85432 ff 000  2 0 0 0 0  1 ff3 ff5  1 ff4 ff5  0 000  1 01
0 1 0abc4 ff 000  4 0 0 0 0  1 abc ffc  0 ff4 ff5  0 000  0 01

// ==== fcore_decoder_config.svh ====
`ifndef FCORE_DECODER_CONFIG_SVH
`define FCORE_DECODER_CONFIG_SVH

// Instruction word and field widths
`define FCORE_INSTR_WIDTH    20
`define FCORE_OPCODE_WIDTH   4
`define FCORE_REG_WIDTH      4
`define FCORE_CHANNEL_WIDTH  8
`define FCORE_ADDR_WIDTH     12
`define FCORE_IMM_WIDTH      12
`define FCORE_OPSEL_WIDTH    6

// Registers per channel bank, each channel owns a contiguous block
`define FCORE_BANK_SIZE      16

// Operation codes sent to the execution unit
`define FCORE_OP_ADD         0
`define FCORE_OP_SUB         1
`define FCORE_OP_BGT         36
`define FCORE_OP_BEQ         20
`define FCORE_OP_CSEL        1

`endif

// ==== fcore_decoder_ifs.sv ====
`timescale 1ns/1ps

// Unpacked instruction fields, already moved into the channel's bank
interface fields_if;
    import fcore_decoder_pkg::*;

    bank_addr_t bank_a;
    bank_addr_t bank_b;
    bank_addr_t bank_dest;
    imm_t       imm;
    logic       io_a;
    logic       io_b;
    logic       io_c;

    modport source (output bank_a, bank_b, bank_dest, imm, io_a, io_b, io_c);
    modport sink   (input  bank_a, bank_b, bank_dest, imm, io_a, io_b, io_c);
endinterface

// Per-opcode control from the decode table to the issue stage
interface issue_ctrl_if;
    import fcore_decoder_pkg::*;

    logic   use_a;
    logic   use_b;
    logic   use_c;
    logic   a_from_imm;
    logic   a_from_const;
    logic   target_from_dest;
    logic   op_valid;
    opsel_t op_code;
    logic   io_use_a;
    logic   io_use_b;
    logic   io_use_c;
    logic   stop;

    modport source (
        output use_a, use_b, use_c, a_from_imm, a_from_const, target_from_dest,
               op_valid, op_code, io_use_a, io_use_b, io_use_c, stop
    );
    modport sink (
        input  use_a, use_b, use_c, a_from_imm, a_from_const, target_from_dest,
               op_valid, op_code, io_use_a, io_use_b, io_use_c, stop
    );
endinterface

// ==== fcore_decoder_pkg.sv ====
`include "fcore_decoder_config.svh"

package fcore_decoder_pkg;

    // Raw instruction word as fetched from program memory
    typedef logic [`FCORE_INSTR_WIDTH-1:0] instr_t;

    // Register number inside one channel's bank
    typedef logic [`FCORE_REG_WIDTH-1:0] reg_num_t;

    typedef logic [`FCORE_CHANNEL_WIDTH-1:0] channel_t;

    // Banked register address, or a constant that travels on an address port
    typedef logic [`FCORE_ADDR_WIDTH-1:0] bank_addr_t;

    typedef logic [`FCORE_IMM_WIDTH-1:0] imm_t;

    // Operation code for the execution unit
    typedef logic [`FCORE_OPSEL_WIDTH-1:0] opsel_t;

    // Supported opcodes; codes above STOP are treated as NOP
    typedef enum logic [`FCORE_OPCODE_WIDTH-1:0] {
        NOP  = 4'd0,
        ADD  = 4'd1,
        SUB  = 4'd2,
        MUL  = 4'd3,
        LDR  = 4'd4,
        LDC  = 4'd5,
        BGT  = 4'd6,
        BEQ  = 4'd7,
        CSEL = 4'd8,
        STOP = 4'd9
    } opcode_e;

endpackage

// ==== fcore_decoder_properties.sv ====
`timescale 1ns/1ps

module fcore_decoder_properties (
    input logic clock,
    input logic arst_n,
    input logic enable,
    input logic core_stop,
    input logic op_a_valid,
    input logic op_b_valid,
    input logic op_c_valid,
    input logic operation_valid
);
    logic any_valid;

    assign any_valid = op_a_valid || op_b_valid || op_c_valid || operation_valid;

    // Port c is only issued by CSEL, which always drives a and b as well
    c_implies_a_b: assert property (
        @(posedge clock) disable iff (!arst_n) op_c_valid |-> (op_a_valid && op_b_valid)
    ) else $error("op_c_valid high without op_a_valid and op_b_valid");

    stop_has_no_valid: assert property (
        @(posedge clock) disable iff (!arst_n) core_stop |-> !any_valid
    ) else $error("core_stop high together with an operand or operation valid");

    // The first edge after release still shows the reset values
    reset_clears_valids: assert property (
        @(posedge clock) $rose(arst_n) |-> !any_valid
    ) else $error("valid high on the first edge after reset release");

    idle_clears_valids: assert property (
        @(posedge clock) disable iff (!arst_n) !enable |=> !any_valid
    ) else $error("valid high on the cycle after enable was low");

endmodule

bind fcore_decoder_top fcore_decoder_properties u_props (
    .clock           (clock),
    .arst_n          (arst_n),
    .enable          (enable),
    .core_stop       (core_stop),
    .op_a_valid      (op_a_valid),
    .op_b_valid      (op_b_valid),
    .op_c_valid      (op_c_valid),
    .operation_valid (operation_valid)
);

// ==== fcore_decoder_top.sv ====
`timescale 1ns/1ps

module fcore_decoder_top (
    input  logic                          clock,
    input  logic                          arst_n,
    input  logic                          enable,
    input  fcore_decoder_pkg::instr_t     instruction,
    input  fcore_decoder_pkg::channel_t   channel,
    input  fcore_decoder_pkg::bank_addr_t load_data,
    output fcore_decoder_pkg::opcode_e    exec_opcode,
    output logic                          io_sel_a,
    output logic                          io_sel_b,
    output logic                          io_sel_c,
    output logic                          core_stop,
    output logic                          op_a_valid,
    output fcore_decoder_pkg::bank_addr_t op_a_addr,
    output fcore_decoder_pkg::bank_addr_t op_a_target,
    output logic                          op_b_valid,
    output fcore_decoder_pkg::bank_addr_t op_b_addr,
    output fcore_decoder_pkg::bank_addr_t op_b_target,
    output logic                          op_c_valid,
    output fcore_decoder_pkg::bank_addr_t op_c_addr,
    output logic                          operation_valid,
    output fcore_decoder_pkg::opsel_t     operation_code
);
    import fcore_decoder_pkg::*;

    opcode_e opcode;

    fields_if     u_fields ();
    issue_ctrl_if u_ctrl ();

    instr_field_unpack u_unpack (
        .instruction (instruction),
        .channel     (channel),
        .opcode      (opcode),
        .fields      (u_fields.source)
    );

    opcode_decode u_decode (
        .opcode (opcode),
        .ctrl   (u_ctrl.source)
    );

    // Single register stage between the instruction and the issue ports
    issue_register u_issue (
        .clock           (clock),
        .arst_n          (arst_n),
        .enable          (enable),
        .opcode          (opcode),
        .load_data       (load_data),
        .fields          (u_fields.sink),
        .ctrl            (u_ctrl.sink),
        .exec_opcode     (exec_opcode),
        .io_sel_a        (io_sel_a),
        .io_sel_b        (io_sel_b),
        .io_sel_c        (io_sel_c),
        .core_stop       (core_stop),
        .op_a_valid      (op_a_valid),
        .op_a_addr       (op_a_addr),
        .op_a_target     (op_a_target),
        .op_b_valid      (op_b_valid),
        .op_b_addr       (op_b_addr),
        .op_b_target     (op_b_target),
        .op_c_valid      (op_c_valid),
        .op_c_addr       (op_c_addr),
        .operation_valid (operation_valid),
        .operation_code  (operation_code)
    );

endmodule

// ==== instr_field_unpack.sv ====
`timescale 1ns/1ps
`include "fcore_decoder_config.svh"

module instr_field_unpack (
    input  fcore_decoder_pkg::instr_t   instruction,
    input  fcore_decoder_pkg::channel_t channel,
    output fcore_decoder_pkg::opcode_e  opcode,
    fields_if.source                    fields
);
    import fcore_decoder_pkg::*;

    localparam int REG_A_LSB = `FCORE_OPCODE_WIDTH;
    localparam int REG_B_LSB = REG_A_LSB + `FCORE_REG_WIDTH;
    localparam int DEST_LSB  = REG_B_LSB + `FCORE_REG_WIDTH;
    localparam int IO_LSB    = DEST_LSB + `FCORE_REG_WIDTH;

    logic [`FCORE_OPCODE_WIDTH-1:0] raw_opcode;
    reg_num_t                       reg_a;
    reg_num_t                       reg_b;
    reg_num_t                       reg_dest;

    // Each channel sees its own block of registers in the shared register file
    function automatic bank_addr_t bank_of(input reg_num_t r, input channel_t ch);
        return bank_addr_t'(r) + bank_addr_t'(ch) * bank_addr_t'(`FCORE_BANK_SIZE);
    endfunction

    assign raw_opcode = instruction[`FCORE_OPCODE_WIDTH-1:0];
    assign reg_a      = instruction[REG_A_LSB +: `FCORE_REG_WIDTH];
    assign reg_b      = instruction[REG_B_LSB +: `FCORE_REG_WIDTH];
    assign reg_dest   = instruction[DEST_LSB +: `FCORE_REG_WIDTH];

    // Unknown codes fold onto NOP so downstream never sees them
    assign opcode = (raw_opcode > STOP) ? NOP : opcode_e'(raw_opcode);

    assign fields.bank_a    = bank_of(reg_a, channel);
    assign fields.bank_b    = bank_of(reg_b, channel);
    assign fields.bank_dest = bank_of(reg_dest, channel);

    // The immediate overlaps the three register fields
    assign fields.imm = instruction[REG_A_LSB +: `FCORE_IMM_WIDTH];

    assign fields.io_a = instruction[IO_LSB];
    assign fields.io_b = instruction[IO_LSB + 1];
    assign fields.io_c = instruction[IO_LSB + 2];

endmodule

// ==== issue_register.sv ====
`timescale 1ns/1ps

module issue_register (
    input  logic                          clock,
    input  logic                          arst_n,
    input  logic                          enable,
    input  fcore_decoder_pkg::opcode_e    opcode,
    input  fcore_decoder_pkg::bank_addr_t load_data,
    fields_if.sink                        fields,
    issue_ctrl_if.sink                    ctrl,
    output fcore_decoder_pkg::opcode_e    exec_opcode,
    output logic                          io_sel_a,
    output logic                          io_sel_b,
    output logic                          io_sel_c,
    output logic                          core_stop,
    output logic                          op_a_valid,
    output fcore_decoder_pkg::bank_addr_t op_a_addr,
    output fcore_decoder_pkg::bank_addr_t op_a_target,
    output logic                          op_b_valid,
    output fcore_decoder_pkg::bank_addr_t op_b_addr,
    output fcore_decoder_pkg::bank_addr_t op_b_target,
    output logic                          op_c_valid,
    output fcore_decoder_pkg::bank_addr_t op_c_addr,
    output logic                          operation_valid,
    output fcore_decoder_pkg::opsel_t     operation_code
);
    import fcore_decoder_pkg::*;

    bank_addr_t a_addr;
    bank_addr_t a_target;
    bank_addr_t b_target;
    logic       issue;

    assign issue = enable && (opcode != NOP);

    // Loads and CSEL write back to register a, everything else uses dest
    assign a_addr   = ctrl.a_from_const ? load_data :
                      ctrl.a_from_imm   ? bank_addr_t'(fields.imm) : fields.bank_a;
    assign a_target = (ctrl.a_from_imm || ctrl.a_from_const || ctrl.use_c) ?
                      fields.bank_a : fields.bank_dest;
    assign b_target = ctrl.use_c            ? fields.bank_a    :
                      ctrl.target_from_dest ? fields.bank_dest : fields.bank_b;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            exec_opcode     <= NOP;
            io_sel_a        <= 1'b0;
            io_sel_b        <= 1'b0;
            io_sel_c        <= 1'b0;
            core_stop       <= 1'b0;
            op_a_valid      <= 1'b0;
            op_a_addr       <= '0;
            op_a_target     <= '0;
            op_b_valid      <= 1'b0;
            op_b_addr       <= '0;
            op_b_target     <= '0;
            op_c_valid      <= 1'b0;
            op_c_addr       <= '0;
            operation_valid <= 1'b0;
            operation_code  <= '0;
        end else begin
            // Valids and stop are single-cycle pulses
            op_a_valid      <= 1'b0;
            op_b_valid      <= 1'b0;
            op_c_valid      <= 1'b0;
            operation_valid <= 1'b0;
            core_stop       <= 1'b0;
            if (issue) begin
                exec_opcode <= opcode;
                core_stop   <= ctrl.stop;
                if (ctrl.use_a) begin
                    op_a_valid  <= 1'b1;
                    op_a_addr   <= a_addr;
                    op_a_target <= a_target;
                end
                if (ctrl.use_b) begin
                    op_b_valid  <= 1'b1;
                    op_b_addr   <= fields.bank_b;
                    op_b_target <= b_target;
                end
                if (ctrl.use_c) begin
                    op_c_valid <= 1'b1;
                    op_c_addr  <= fields.bank_dest;
                end
                if (ctrl.op_valid) begin
                    operation_valid <= 1'b1;
                    operation_code  <= ctrl.op_code;
                end
                // Selects not touched by this opcode hold their last value
                if (ctrl.io_use_a) io_sel_a <= fields.io_a;
                if (ctrl.io_use_b) io_sel_b <= fields.io_b;
                if (ctrl.io_use_c) io_sel_c <= fields.io_c;
            end else begin
                exec_opcode    <= NOP;
                io_sel_a       <= 1'b0;
                io_sel_b       <= 1'b0;
                io_sel_c       <= 1'b0;
                op_a_addr      <= '0;
                op_a_target    <= '0;
                op_b_addr      <= '0;
                op_b_target    <= '0;
                op_c_addr      <= '0;
                operation_code <= '0;
            end
        end
    end

endmodule

// ==== opcode_decode.sv ====
`timescale 1ns/1ps
`include "fcore_decoder_config.svh"

module opcode_decode (
    input  fcore_decoder_pkg::opcode_e opcode,
    issue_ctrl_if.source               ctrl
);
    import fcore_decoder_pkg::*;

    always_comb begin
        // Anything not listed below behaves as NOP
        ctrl.use_a            = 1'b0;
        ctrl.use_b            = 1'b0;
        ctrl.use_c            = 1'b0;
        ctrl.a_from_imm       = 1'b0;
        ctrl.a_from_const     = 1'b0;
        ctrl.target_from_dest = 1'b0;
        ctrl.op_valid         = 1'b0;
        ctrl.op_code          = '0;
        ctrl.io_use_a         = 1'b0;
        ctrl.io_use_b         = 1'b0;
        ctrl.io_use_c         = 1'b0;
        ctrl.stop             = 1'b0;

        case (opcode)
            ADD, SUB, BGT, BEQ: begin
                ctrl.use_a            = 1'b1;
                ctrl.use_b            = 1'b1;
                ctrl.target_from_dest = 1'b1;
                ctrl.op_valid         = 1'b1;
                ctrl.io_use_a         = 1'b1;
                ctrl.io_use_b         = 1'b1;
                case (opcode)
                    SUB:     ctrl.op_code = opsel_t'(`FCORE_OP_SUB);
                    BGT:     ctrl.op_code = opsel_t'(`FCORE_OP_BGT);
                    BEQ:     ctrl.op_code = opsel_t'(`FCORE_OP_BEQ);
                    default: ctrl.op_code = opsel_t'(`FCORE_OP_ADD);
                endcase
            end
            MUL: begin
                // The multiplier has no operation code; port b writes back to register b
                ctrl.use_a    = 1'b1;
                ctrl.use_b    = 1'b1;
                ctrl.io_use_a = 1'b1;
                ctrl.io_use_b = 1'b1;
            end
            LDR: begin
                ctrl.use_a      = 1'b1;
                ctrl.a_from_imm = 1'b1;
            end
            LDC: begin
                ctrl.use_a        = 1'b1;
                ctrl.a_from_const = 1'b1;
            end
            CSEL: begin
                ctrl.use_a    = 1'b1;
                ctrl.use_b    = 1'b1;
                ctrl.use_c    = 1'b1;
                ctrl.op_valid = 1'b1;
                ctrl.op_code  = opsel_t'(`FCORE_OP_CSEL);
                ctrl.io_use_a = 1'b1;
                ctrl.io_use_b = 1'b1;
                ctrl.io_use_c = 1'b1;
            end
            STOP: begin
                ctrl.stop = 1'b1;
            end
            default: begin
                ctrl.stop = 1'b0;
            end
        endcase
    end

endmodule

// ==== tb_fcore_decoder.sv ====
`timescale 1ns/1ps

module tb_fcore_decoder;
    import fcore_decoder_pkg::*;

    localparam int    HALF_PERIOD   = 4;
    localparam int    RESET_CYCLES  = 4;
    localparam int    RESET_TIMEOUT = 20;
    localparam int    MAX_LINES     = 1000;
    localparam string VEC_FILE      = "decoder_vectors.txt";

    logic       clock;
    logic       arst_n;
    logic       enable;
    instr_t     instruction;
    channel_t   channel;
    bank_addr_t load_data;
    opcode_e    exec_opcode;
    logic       io_sel_a;
    logic       io_sel_b;
    logic       io_sel_c;
    logic       core_stop;
    logic       op_a_valid;
    bank_addr_t op_a_addr;
    bank_addr_t op_a_target;
    logic       op_b_valid;
    bank_addr_t op_b_addr;
    bank_addr_t op_b_target;
    logic       op_c_valid;
    bank_addr_t op_c_addr;
    logic       operation_valid;
    opsel_t     operation_code;

    // Columns of one vector line: gap, enable, instruction, channel, load_data, then outputs
    logic [19:0] col [20];
    integer      seed;
    int          n_vectors;

    fcore_decoder_top u_dut (.*);

    initial begin
        clock = 1'b0;
        forever #HALF_PERIOD clock = ~clock;
    end

    // Release lands on a falling edge, like every other input change
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
    end

    task automatic stop_with_failure(input string reason);
        $display("RESULT: FAIL");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_value(input string name, input logic [19:0] actual,
                               input logic [19:0] expected);
        assert (actual === expected) else begin
            $display("FAILED time=%0t signal=%s expected=%0h actual=%0h",
                     $time, name, expected, actual);
            stop_with_failure("output mismatch");
        end
    endtask

    task automatic compare_outputs(input logic [19:0] expected [20]);
        check_value("exec_opcode", 20'(exec_opcode), expected[5]);
        check_value("io_sel_a", 20'(io_sel_a), expected[6]);
        check_value("io_sel_b", 20'(io_sel_b), expected[7]);
        check_value("io_sel_c", 20'(io_sel_c), expected[8]);
        check_value("core_stop", 20'(core_stop), expected[9]);
        check_value("op_a_valid", 20'(op_a_valid), expected[10]);
        check_value("op_a_addr", 20'(op_a_addr), expected[11]);
        check_value("op_a_target", 20'(op_a_target), expected[12]);
        check_value("op_b_valid", 20'(op_b_valid), expected[13]);
        check_value("op_b_addr", 20'(op_b_addr), expected[14]);
        check_value("op_b_target", 20'(op_b_target), expected[15]);
        check_value("op_c_valid", 20'(op_c_valid), expected[16]);
        check_value("op_c_addr", 20'(op_c_addr), expected[17]);
        check_value("operation_valid", 20'(operation_valid), expected[18]);
        check_value("operation_code", 20'(operation_code), expected[19]);
    endtask

    task automatic wait_for_reset_release();
        int cycles;
        cycles = 0;
        while (arst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        assert (arst_n === 1'b1) else begin
            $display("ERROR: reset was not released within %0d cycles", RESET_TIMEOUT);
            stop_with_failure("reset timeout");
        end
    endtask

    // Enable low with random garbage on the other inputs must give all zeros
    task automatic run_idle_cycle();
        logic [31:0] rnd;
        logic [19:0] zeros [20];
        zeros = '{default: '0};
        rnd = $random(seed);
        enable      = 1'b0;
        instruction = rnd[19:0];
        channel     = rnd[27:20];
        load_data   = rnd[31:20];
        @(negedge clock);
        compare_outputs(zeros);
    endtask

    task automatic apply_vector();
        enable      = col[1][0];
        instruction = col[2];
        channel     = col[3][7:0];
        load_data   = col[4][11:0];
        @(negedge clock);
        compare_outputs(col);
    endtask

    initial begin
        int          fd;
        int          count;
        int          idle_count;
        logic [31:0] rnd;
        string       line;

        seed        = 6855;
        n_vectors   = 0;
        enable      = 1'b0;
        instruction = '0;
        channel     = '0;
        load_data   = '0;
        wait_for_reset_release();
        run_idle_cycle();

        fd = $fopen(VEC_FILE, "r");
        assert (fd != 0) else begin
            $display("ERROR: cannot open vector file %s", VEC_FILE);
            stop_with_failure("missing vector file");
        end
        for (int i = 0; i < MAX_LINES; i++) begin
            if ($fgets(line, fd) == 0) begin
                break;
            end
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            count = $sscanf(line,
                "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
                col[8], col[9], col[10], col[11], col[12], col[13], col[14],
                col[15], col[16], col[17], col[18], col[19]);
            assert (count == 20) else begin
                $display("ERROR: line %0d of %s is not a complete vector", i + 1, VEC_FILE);
                stop_with_failure("bad vector line");
            end
            // Idle gaps only where the previous state cannot leak into this line
            if (col[0][0]) begin
                rnd = $random(seed);
                idle_count = rnd % 32'd3;
                repeat (idle_count) run_idle_cycle();
            end
            apply_vector();
            n_vectors++;
        end
        $fclose(fd);
        run_idle_cycle();
        run_idle_cycle();

        if (n_vectors == 0) begin
            $display("ERROR: vector file %s holds no vectors", VEC_FILE);
            stop_with_failure("empty vector file");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule
